//--- hdl/customInstruction_settings.svh
`ifndef CUSTOM_INSTRUCTION_SETTINGS_SVH
`define CUSTOM_INSTRUCTION_SETTINGS_SVH

// ====================
// Data path widths.
// ====================
`define CI_DATA_WIDTH 32
`define CI_ID_WIDTH 8

// Instruction numbers claimed by this unit.
`define CI_SWAP_BYTE_ID 1
`define CI_DELAY_ID 6

// Operations buffered between decoder and execution stage.
`define CI_QUEUE_DEPTH 4

// System clocks in one microsecond.
`define CI_CLOCKS_PER_MICROSECOND 10

`endif

//--- hdl/ciRequestPkg.sv
`include "customInstruction_settings.svh"

package ciRequestPkg;

  // ====================
  // Operand word.
  // ====================

  // One word seen as a count or as four bytes.
  typedef union packed {
    logic [`CI_DATA_WIDTH-1:0] word;
    logic [3:0][7:0]           bytes;
  } ciOperand_t;

  // What the processor hands over.
  typedef struct packed {
    logic [`CI_ID_WIDTH-1:0] instructionNumber;
    ciOperand_t              operandA;
    ciOperand_t              operandB;
  } ciRequest_t;

  // ====================
  // Decoded operation.
  // ====================
  typedef enum logic [1:0] {
    opSwapByte = 2'd0,
    opDelay    = 2'd1,
    opIllegal  = 2'd2
  } ciOperation_t;

  typedef struct packed {
    ciOperation_t operation;
    ciOperand_t   operandA;
    ciOperand_t   operandB;
  } ciDecoded_t;

endpackage

//--- hdl/ciResultPkg.sv
`include "customInstruction_settings.svh"

package ciResultPkg;

  // ====================
  // Result returned.
  // ====================

  // Illegal is set for instruction numbers nobody claims.
  typedef struct packed {
    logic [`CI_DATA_WIDTH-1:0] word;
    logic                      illegal;
  } ciResult_t;

endpackage

//--- hdl/ciRequestDecoder.sv
`include "customInstruction_settings.svh"

module ciRequestDecoder (
  input  logic                     s_systemClock,
  input  logic                     s_pllLocked,
  input  logic                     requestValid,
  output logic                     requestReady,
  input  ciRequestPkg::ciRequest_t request,
  output logic                     decodedValid,
  input  logic                     decodedReady,
  output ciRequestPkg::ciDecoded_t decoded
);

  ciRequestPkg::ciOperation_t nextOperation;
  logic                       requestAccepted;

  // Register is free when empty or drained this cycle.
  assign requestReady    = ~decodedValid | decodedReady;
  assign requestAccepted = requestValid & requestReady;

  // Only this block decides what is illegal.
  always_comb begin
    case (request.instructionNumber)
      `CI_ID_WIDTH'(`CI_SWAP_BYTE_ID): nextOperation = ciRequestPkg::opSwapByte;
      `CI_ID_WIDTH'(`CI_DELAY_ID):     nextOperation = ciRequestPkg::opDelay;
      default:                         nextOperation = ciRequestPkg::opIllegal;
    endcase
  end

  // ====================
  // Output stage.
  // ====================
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      decodedValid <= 1'b0;
    end else if (requestAccepted) begin
      decodedValid <= 1'b1;
    end else if (decodedReady) begin
      decodedValid <= 1'b0;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (requestAccepted) begin
      decoded.operation <= nextOperation;
      decoded.operandA  <= request.operandA;
      decoded.operandB  <= request.operandB;
    end
  end

endmodule

//--- hdl/ciQueue.sv
`include "customInstruction_settings.svh"

module ciQueue #(
  parameter int DEPTH = `CI_QUEUE_DEPTH
) (
  input  logic                     s_systemClock,
  input  logic                     s_pllLocked,
  input  logic                     writeValid,
  output logic                     writeReady,
  input  ciRequestPkg::ciDecoded_t writeData,
  output logic                     readValid,
  input  logic                     readReady,
  output ciRequestPkg::ciDecoded_t readData
);

  localparam int ADDR_WIDTH = $clog2(DEPTH);
  localparam logic [ADDR_WIDTH:0] FULL_COUNT = (ADDR_WIDTH + 1)'(DEPTH);

  ciRequestPkg::ciDecoded_t memory [DEPTH];
  logic [ADDR_WIDTH-1:0]    writePointer;
  logic [ADDR_WIDTH-1:0]    readPointer;
  logic [ADDR_WIDTH:0]      count;
  logic                     push;
  logic                     pop;

  assign writeReady = (count != FULL_COUNT);
  assign readValid  = (count != '0);
  assign readData   = memory[readPointer];

  assign push = writeValid & writeReady;
  assign pop  = readValid & readReady;

  // ====================
  // Pointers and fill level.
  // ====================

  // Depth is a power of two, so pointers wrap on their own.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      writePointer <= '0;
      readPointer  <= '0;
      count        <= '0;
    end else begin
      if (push) begin
        writePointer <= writePointer + 1'b1;
      end
      if (pop) begin
        readPointer <= readPointer + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage.
  always_ff @(posedge s_systemClock) begin
    if (push) begin
      memory[writePointer] <= writeData;
    end
  end

endmodule

//--- hdl/microsecondTimer.sv
`include "customInstruction_settings.svh"

module microsecondTimer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  input  logic restart,
  output logic tick
);

  localparam int COUNT_WIDTH = $clog2(`CI_CLOCKS_PER_MICROSECOND + 1);
  localparam logic [COUNT_WIDTH-1:0] LAST_COUNT =
    COUNT_WIDTH'(`CI_CLOCKS_PER_MICROSECOND - 1);

  logic [COUNT_WIDTH-1:0] counter;

  // Tick in the last clock of each microsecond.
  assign tick = (counter == LAST_COUNT);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      counter <= '0;
    end else if (restart || tick) begin
      counter <= '0;
    end else begin
      counter <= counter + 1'b1;
    end
  end

endmodule

//--- hdl/ciExecute.sv
`include "customInstruction_settings.svh"

module ciExecute (
  input  logic                     s_systemClock,
  input  logic                     s_pllLocked,
  input  logic                     operationValid,
  output logic                     operationReady,
  input  ciRequestPkg::ciDecoded_t operation,
  output logic                     resultValid,
  input  logic                     resultReady,
  output ciResultPkg::ciResult_t   result
);

  logic                       delayBusy;
  logic [`CI_DATA_WIDTH-1:0]  delayCount;
  logic                       pop;
  logic                       timerRestart;
  logic                       microsecondTick;
  ciRequestPkg::ciOperand_t   swapped;

  // One operation at a time, and only with an empty result register.
  assign operationReady = ~delayBusy & ~resultValid;
  assign pop            = operationValid & operationReady;
  assign timerRestart   = pop;

  microsecondTimer u_microsecondTimer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .restart      (timerRestart),
    .tick         (microsecondTick)
  );

  // ====================
  // Byte swap.
  // ====================
  always_comb begin
    if (operation.operandB.word[0]) begin
      // Swap within each halfword.
      swapped.bytes[3] = operation.operandA.bytes[2];
      swapped.bytes[2] = operation.operandA.bytes[3];
      swapped.bytes[1] = operation.operandA.bytes[0];
      swapped.bytes[0] = operation.operandA.bytes[1];
    end else begin
      // Full reversal.
      swapped.bytes[3] = operation.operandA.bytes[0];
      swapped.bytes[2] = operation.operandA.bytes[1];
      swapped.bytes[1] = operation.operandA.bytes[2];
      swapped.bytes[0] = operation.operandA.bytes[3];
    end
  end

  // ====================
  // Control.
  // ====================
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      delayBusy   <= 1'b0;
      resultValid <= 1'b0;
    end else begin
      if (resultValid && resultReady) begin
        resultValid <= 1'b0;
      end
      if (pop) begin
        if (operation.operation != ciRequestPkg::opDelay ||
            operation.operandA.word == '0) begin
          resultValid <= 1'b1;
        end else begin
          delayBusy <= 1'b1;
        end
      end else if (delayBusy && microsecondTick && delayCount == 1) begin
        delayBusy   <= 1'b0;
        resultValid <= 1'b1;
      end
    end
  end

  // Count and result payload.
  always_ff @(posedge s_systemClock) begin
    if (pop) begin
      delayCount <= operation.operandA.word;
      case (operation.operation)
        ciRequestPkg::opSwapByte: result <= '{word: swapped.word, illegal: 1'b0};
        ciRequestPkg::opDelay:    result <= '{word: '0, illegal: 1'b0};
        default:                  result <= '{word: '0, illegal: 1'b1};
      endcase
    end else if (delayBusy && microsecondTick) begin
      delayCount <= delayCount - 1'b1;
    end
  end

endmodule

//--- hdl/customInstructionUnit.sv
module customInstructionUnit (
  input  logic                     s_systemClock,
  input  logic                     s_pllLocked,
  input  logic                     requestValid,
  output logic                     requestReady,
  input  ciRequestPkg::ciRequest_t request,
  output logic                     resultValid,
  input  logic                     resultReady,
  output ciResultPkg::ciResult_t   result
);

  // Decoder to queue.
  logic                     decodedValid;
  logic                     decodedReady;
  ciRequestPkg::ciDecoded_t decoded;

  // Queue to execution stage.
  logic                     operationValid;
  logic                     operationReady;
  ciRequestPkg::ciDecoded_t operation;

  ciRequestDecoder u_requestDecoder (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .requestValid (requestValid),
    .requestReady (requestReady),
    .request      (request),
    .decodedValid (decodedValid),
    .decodedReady (decodedReady),
    .decoded      (decoded)
  );

  ciQueue u_queue (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .writeValid   (decodedValid),
    .writeReady   (decodedReady),
    .writeData    (decoded),
    .readValid    (operationValid),
    .readReady    (operationReady),
    .readData     (operation)
  );

  ciExecute u_execute (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .operationValid(operationValid),
    .operationReady(operationReady),
    .operation     (operation),
    .resultValid   (resultValid),
    .resultReady   (resultReady),
    .result        (result)
  );

endmodule

//--- bench/customInstructionUnit_props.sv
`include "customInstruction_settings.svh"

module customInstructionUnitProps (
  input logic                   s_systemClock,
  input logic                   s_pllLocked,
  input logic                   resultValid,
  input logic                   resultReady,
  input ciResultPkg::ciResult_t result,
  input logic                   decodedValid,
  input logic                   decodedReady,
  input logic                   operationValid,
  input logic                   operationReady
);

  int unsigned occupancy;
  int unsigned failureCount = 0;
  logic        queuePush;
  logic        queuePop;

  assign queuePush = decodedValid & decodedReady;
  assign queuePop  = operationValid & operationReady;

  // Queue fill level, seen from its two handshakes.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      occupancy <= 0;
    end else begin
      case ({queuePush, queuePop})
        2'b10:   occupancy <= occupancy + 1;
        2'b01:   occupancy <= occupancy - 1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // ====================
  // Properties.
  // ====================
  resultHeld: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    resultValid && !resultReady |=> resultValid && $stable(result))
    else begin
      failureCount++;
      $error("result changed or dropped while resultReady was low");
    end

  noWriteWhenFull: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    queuePush |-> occupancy < `CI_QUEUE_DEPTH)
    else begin
      failureCount++;
      $error("operation queue written while full");
    end

  resultValidKnown: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !$isunknown(resultValid))
    else begin
      failureCount++;
      $error("resultValid is unknown after reset");
    end

endmodule

//--- bench/customInstructionUnitTb.sv
`include "customInstruction_settings.svh"

module customInstructionUnitTb;

  localparam time         CLOCK_PERIOD  = 8;
  localparam int          RESET_CYCLES  = 8;
  localparam int          REQUEST_COUNT = 300;
  localparam int          MAX_DELAY     = 7;
  localparam int unsigned SEED          = 32'hadf6;
  localparam time         WATCHDOG_TIME =
    time'(REQUEST_COUNT * (MAX_DELAY * `CI_CLOCKS_PER_MICROSECOND + 20)) * CLOCK_PERIOD;

  logic                     s_systemClock;
  logic                     s_pllLocked;
  logic                     requestValid;
  logic                     requestReady;
  ciRequestPkg::ciRequest_t request;
  logic                     resultValid;
  logic                     resultReady;
  ciResultPkg::ciResult_t   result;

  // Reference model state with one entry per accepted request.
  ciResultPkg::ciResult_t expectedResults[$];
  time                    minimumCycles[$];
  time                    acceptTimes[$];
  int                     acceptedCount;
  int                     resultCount;
  logic                   resultSeen;
  time                    firstSeenTime;

  customInstructionUnit u_customInstructionUnit (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .requestValid (requestValid),
    .requestReady (requestReady),
    .request      (request),
    .resultValid  (resultValid),
    .resultReady  (resultReady),
    .result       (result)
  );

  bind customInstructionUnit customInstructionUnitProps u_customInstructionUnitProps (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .resultValid   (resultValid),
    .resultReady   (resultReady),
    .result        (result),
    .decodedValid  (decodedValid),
    .decodedReady  (decodedReady),
    .operationValid(operationValid),
    .operationReady(operationReady)
  );

  initial s_systemClock = 1'b0;
  always #(CLOCK_PERIOD / 2) s_systemClock = ~s_systemClock;

  // ====================
  // Model and checks.
  // ====================
  function automatic ciResultPkg::ciResult_t modelResult(input ciRequestPkg::ciRequest_t req);
    ciResultPkg::ciResult_t    expected;
    logic [`CI_DATA_WIDTH-1:0] a;
    a = req.operandA.word;
    expected.word    = '0;
    expected.illegal = 1'b0;
    if (req.instructionNumber == `CI_ID_WIDTH'(`CI_SWAP_BYTE_ID)) begin
      if (req.operandB.word[0]) begin
        expected.word = {a[23:16], a[31:24], a[7:0], a[15:8]};
      end else begin
        expected.word = {a[7:0], a[15:8], a[23:16], a[31:24]};
      end
    end else if (req.instructionNumber != `CI_ID_WIDTH'(`CI_DELAY_ID)) begin
      expected.illegal = 1'b1;
    end
    return expected;
  endfunction

  // Mostly swap and delay with some random numbers.
  function automatic ciRequestPkg::ciRequest_t randomRequest();
    ciRequestPkg::ciRequest_t req;
    int unsigned              pick;
    pick = $urandom_range(0, 9);
    if (pick < 4) begin
      req.instructionNumber = `CI_ID_WIDTH'(`CI_SWAP_BYTE_ID);
    end else if (pick < 8) begin
      req.instructionNumber = `CI_ID_WIDTH'(`CI_DELAY_ID);
    end else begin
      req.instructionNumber = `CI_ID_WIDTH'($urandom);
    end
    req.operandA.word = $urandom;
    req.operandB.word = $urandom;
    if (req.instructionNumber == `CI_ID_WIDTH'(`CI_DELAY_ID)) begin
      req.operandA.word = $urandom_range(0, MAX_DELAY);
    end
    return req;
  endfunction

  task automatic stopOnFailure();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic compareWord(input ciResultPkg::ciResult_t expected,
                             input ciResultPkg::ciResult_t actual);
    if (actual.word !== expected.word) begin
      $display("error at %0t: result.word expected %08h actual %08h",
               $time, expected.word, actual.word);
      stopOnFailure();
    end
  endtask

  task automatic compareIllegal(input ciResultPkg::ciResult_t expected,
                                input ciResultPkg::ciResult_t actual);
    if (actual.illegal !== expected.illegal) begin
      $display("error at %0t: result.illegal expected %b actual %b",
               $time, expected.illegal, actual.illegal);
      stopOnFailure();
    end
  endtask

  task automatic recordAccepted(input ciRequestPkg::ciRequest_t accepted);
    expectedResults.push_back(modelResult(accepted));
    if (accepted.instructionNumber == `CI_ID_WIDTH'(`CI_DELAY_ID)) begin
      minimumCycles.push_back(time'(accepted.operandA.word) * `CI_CLOCKS_PER_MICROSECOND);
    end else begin
      minimumCycles.push_back(0);
    end
    acceptTimes.push_back($time);
    acceptedCount++;
  endtask

  // Accept and first-seen times are both taken at falling edges.
  task automatic checkResult();
    ciResultPkg::ciResult_t expected;
    time                    minimum;
    time                    accepted;
    time                    elapsed;
    if (expectedResults.size() == 0) begin
      $display("A result arrived at %0t without a matching request.", $time);
      stopOnFailure();
    end else begin
      expected = expectedResults.pop_front();
      minimum  = minimumCycles.pop_front();
      accepted = acceptTimes.pop_front();
      compareWord(expected, result);
      compareIllegal(expected, result);
      elapsed = (firstSeenTime - accepted) / CLOCK_PERIOD - 1;
      if (elapsed < minimum) begin
        $display("Delay finished at %0t after %0d cycles, but needs at least %0d.",
                 $time, elapsed, minimum);
        stopOnFailure();
      end
    end
  endtask

  // ====================
  // Processes.
  // ====================
  initial begin : stimulus
    ciRequestPkg::ciRequest_t nextRequest;
    int unsigned              gap;
    logic                     taken;
    logic                     lateResult;
    int                       i;
    void'($urandom(SEED));
    s_pllLocked   = 1'b0;
    requestValid  = 1'b0;
    request       = '0;
    resultReady   = 1'b0;
    acceptedCount = 0;
    resultCount   = 0;
    resultSeen    = 1'b0;
    firstSeenTime = 0;
    lateResult    = 1'b0;
    repeat (RESET_CYCLES) @(posedge s_systemClock);
    #1;
    s_pllLocked = 1'b1;
    for (i = 0; i < REQUEST_COUNT; i++) begin
      nextRequest  = randomRequest();
      requestValid = 1'b1;
      request      = nextRequest;
      taken        = 1'b0;
      while (!taken) begin
        @(negedge s_systemClock);
        if (requestReady) begin
          taken = 1'b1;
          recordAccepted(nextRequest);
        end
        @(posedge s_systemClock);
        #1;
      end
      requestValid = 1'b0;
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        @(posedge s_systemClock);
        #1;
      end
    end
    wait (resultCount == acceptedCount);
    // Nothing more may come out once every request is answered.
    repeat (4) begin
      @(negedge s_systemClock);
      if (resultValid) begin
        lateResult = 1'b1;
      end
    end
    if (!lateResult) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("A result appeared after all %0d requests were answered.", acceptedCount);
      stopOnFailure();
    end
  end

  initial begin : resultSide
    @(posedge s_pllLocked);
    forever begin
      @(negedge s_systemClock);
      if (resultValid) begin
        if (!resultSeen) begin
          resultSeen    = 1'b1;
          firstSeenTime = $time;
        end
        if (resultReady) begin
          checkResult();
          resultSeen = 1'b0;
          resultCount++;
        end
      end
      @(posedge s_systemClock);
      #1;
      resultReady = ($urandom_range(0, 2) != 0);
    end
  end

  always @(negedge s_systemClock) begin
    if (u_customInstructionUnit.u_customInstructionUnitProps.failureCount != 0) begin
      $display("A bound assertion on the DUT failed before %0t.", $time);
      stopOnFailure();
    end
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("Timeout after %0t time units with %0d of %0d results received.",
             WATCHDOG_TIME, resultCount, REQUEST_COUNT);
    stopOnFailure();
  end

endmodule

//--- vlog.f
+incdir+hdl
hdl/ciRequestPkg.sv
hdl/ciResultPkg.sv
hdl/ciRequestDecoder.sv
hdl/ciQueue.sv
hdl/microsecondTimer.sv
hdl/ciExecute.sv
hdl/customInstructionUnit.sv
bench/customInstructionUnit_props.sv
bench/customInstructionUnitTb.sv

//--- Makefile
VERILATOR := verilator
TOP       := customInstructionUnitTb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
FLAGS     := --timing --assert
SIM_ARGS  := +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# A $fatal in the testbench gives a non-zero exit status.
sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
